/* tb.f */
design/video_pkg.sv
design/vga_timing_gen.sv
design/video_bar_regs.sv
design/video_bar_core.sv
design/video_daisy_system.sv
bench/tb_clk_gen.sv
bench/tb_video_daisy_system.sv

/* run.sh */
#!/bin/sh
# Compile and run the video subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_video_daisy_system \
   -f tb.f -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Verdict comes from the log
if grep -q "CHECKS FAILED" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

/* bench/tb_video_daisy_system.sv */
`timescale 1ns/1ps

module tb_video_daisy_system
   import video_pkg::*;
();

   localparam int CLK_NS      = 4;
   localparam int FRAME_CYC   = int'(H_TOTAL) * int'(V_TOTAL);   // 420000
   localparam int RUN_FRAMES  = 6;          // Five test frames plus first vblank
   localparam int WATCHDOG_NS = (RUN_FRAMES + 4) * FRAME_CYC * CLK_NS;
   localparam int MAX_PRINTS  = 40;

   logic                  clk;
   logic                  arst_n;
   logic [REG_ADDR_W-1:0] reg_addr;
   logic                  reg_write;
   bar_reg_u              reg_wdata;
   logic [3:0]            vga_r;
   logic [3:0]            vga_g;
   logic [3:0]            vga_b;
   logic                  vga_hsync;
   logic                  vga_vsync;
   logic                  vga_blank_n;

   // Expected bar setup, follows every register write
   logic        exp_enable;
   logic        exp_mode;
   logic [11:0] exp_pal [NUM_BARS];
   logic [31:0] lfsr;
   int          test_errs;

   // Monitor state
   logic        prev_hs, prev_vs, prev_blank;
   logic        frame_on;                   // Frame start seen
   logic        seen_hs;
   logic        in_vblank;
   logic [11:0] px_exp;
   int          frame_cyc, vs_low_cyc, line_cnt, active_lines;
   int          line_cyc, hs_low_cyc, blank_cyc;
   int          x_pos, y_pos, y_next;
   int          mon_errs = 0;
   int          pix_cnt = 0;
   int          frames_checked = 0;

   tb_clk_gen u_clk_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   video_daisy_system uut (
      .pixel_clk   (clk),
      .arst_n      (arst_n),
      .reg_addr    (reg_addr),
      .reg_write   (reg_write),
      .reg_wdata   (reg_wdata),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_n (vga_blank_n)
   );

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      if (mon_errs + test_errs <= MAX_PRINTS) begin
         $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
      end
   endtask

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic random_colour(output logic [11:0] colour);
      colour = '0;
      repeat (12) begin
         lfsr   = lfsr_step(lfsr);              // One step per bit
         colour = {colour[10:0], lfsr[0]};
      end
   endtask

   // Bar colour at a visible position
   function automatic logic [11:0] expected_colour(input int x, input int y);
      int                   idx;
      logic [PAL_IDX_W-1:0] sel;
      idx = exp_mode ? (y / int'(BAR_H)) : (x / int'(BAR_W));
      if (!exp_enable || idx >= NUM_BARS) begin
         return 12'h000;
      end
      sel = PAL_IDX_W'(idx);
      return exp_pal[sel];
   endfunction

   task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input bar_reg_u data);
      @(negedge clk);
      reg_addr  = addr;
      reg_wdata = data;
      reg_write = 1'b1;                         // One-cycle strobe
      @(negedge clk);
      reg_write = 1'b0;
   endtask

   task automatic write_ctrl(input logic mode, input logic enable);
      bar_reg_u w;
      w             = '0;
      w.ctrl.mode   = mode;
      w.ctrl.enable = enable;
      write_reg(ADDR_CTRL, w);
   endtask

   task automatic wait_vblank();
      wait (in_vblank === 1'b1);
   endtask

   // Frame ends at the next vsync fall
   task automatic check_frame();
      int n;
      n = frames_checked;
      wait (frames_checked != n);
   endtask

   // ----------------------------------------------------------------------
   // Raster monitor, position from the pins only
   // ----------------------------------------------------------------------
   task automatic line_done();
      if (line_cyc != int'(H_TOTAL)) begin
         mon_errs++;
         report_mismatch("line_cycles", line_cyc, int'(H_TOTAL));
      end
      if (hs_low_cyc != int'(H_SYNC)) begin
         mon_errs++;
         report_mismatch("vga_hsync_low", hs_low_cyc, int'(H_SYNC));
      end
      if (blank_cyc != 0 && blank_cyc != int'(H_ACTIVE)) begin
         mon_errs++;
         report_mismatch("vga_blank_n_high", blank_cyc, int'(H_ACTIVE));
      end
   endtask

   task automatic frame_done();
      if (frame_cyc != FRAME_CYC) begin
         mon_errs++;
         report_mismatch("frame_cycles", frame_cyc, FRAME_CYC);
      end
      if (line_cnt != int'(V_TOTAL)) begin
         mon_errs++;
         report_mismatch("frame_lines", line_cnt, int'(V_TOTAL));
      end
      if (vs_low_cyc != int'(V_SYNC) * int'(H_TOTAL)) begin
         mon_errs++;
         report_mismatch("vga_vsync_low", vs_low_cyc, int'(V_SYNC) * int'(H_TOTAL));
      end
      if (active_lines != int'(V_ACTIVE)) begin
         mon_errs++;
         report_mismatch("active_lines", active_lines, int'(V_ACTIVE));
      end
      frames_checked++;
   endtask

   always @(posedge clk) begin
      if (!arst_n) begin
         prev_hs    = 1'b1;
         prev_vs    = 1'b1;
         prev_blank = 1'b0;
         frame_on   = 1'b0;
         seen_hs    = 1'b0;
         in_vblank  = 1'b0;
      end else begin
         if (!vga_blank_n && {vga_r, vga_g, vga_b} !== 12'h000) begin
            mon_errs++;
            report_mismatch("rgb_in_blank", 32'({vga_r, vga_g, vga_b}), 32'h0);
         end
         if (prev_vs && !vga_vsync) begin      // Frame boundary
            if (frame_on) begin
               frame_done();
            end
            frame_on     = 1'b1;
            in_vblank    = 1'b1;
            frame_cyc    = 0;
            vs_low_cyc   = 0;
            line_cnt     = 0;
            active_lines = 0;
            y_next       = 0;
         end
         if (frame_on && prev_hs && !vga_hsync) begin   // Line boundary
            if (seen_hs) begin
               line_done();
            end
            seen_hs    = 1'b1;
            line_cnt++;
            line_cyc   = 0;
            hs_low_cyc = 0;
            blank_cyc  = 0;
         end
         if (frame_on && !prev_blank && vga_blank_n) begin
            in_vblank = 1'b0;                  // First visible line ends vblank
            x_pos     = 0;
            y_pos     = y_next;
            y_next++;
            active_lines++;
         end
         if (frame_on) begin
            frame_cyc++;
            line_cyc++;
            if (!vga_vsync) vs_low_cyc++;
            if (!vga_hsync) hs_low_cyc++;
            if (vga_blank_n) begin
               px_exp = expected_colour(x_pos, y_pos);
               if ({vga_r, vga_g, vga_b} !== px_exp) begin
                  mon_errs++;
                  report_mismatch("rgb", 32'({vga_r, vga_g, vga_b}), 32'(px_exp));
               end
               pix_cnt++;
               x_pos++;
               blank_cyc++;
            end
         end
         prev_hs    = vga_hsync;
         prev_vs    = vga_vsync;
         prev_blank = vga_blank_n;
      end
   end

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------
   task automatic idle_outputs_check();
      if (vga_hsync !== 1'b1) begin
         test_errs++;
         report_mismatch("vga_hsync", 32'(vga_hsync), 32'h1);
      end
      if (vga_vsync !== 1'b1) begin
         test_errs++;
         report_mismatch("vga_vsync", 32'(vga_vsync), 32'h1);
      end
      if (vga_blank_n !== 1'b0) begin
         test_errs++;
         report_mismatch("vga_blank_n", 32'(vga_blank_n), 32'h0);
      end
      if ({vga_r, vga_g, vga_b} !== 12'h000) begin
         test_errs++;
         report_mismatch("rgb", 32'({vga_r, vga_g, vga_b}), 32'h0);
      end
   endtask

   task automatic reset_levels();
      @(posedge clk);
      @(negedge clk);
      idle_outputs_check();                     // Still in reset
      wait (arst_n === 1'b1);
      @(posedge clk);
      @(negedge clk);
      idle_outputs_check();                     // First cycle out of reset
   endtask

   task automatic default_pattern();
      wait_vblank();
      check_frame();
   endtask

   task automatic random_palette();
      logic [11:0] col;
      bar_reg_u    w;
      wait_vblank();
      for (int i = 0; i < NUM_BARS; i++) begin
         random_colour(col);
         w          = '0;
         w.pal.color = col;
         write_reg(REG_ADDR_W'(int'(ADDR_PAL_BASE) + i), w);
         exp_pal[PAL_IDX_W'(i)] = col;
      end
      w = 32'h0000_0002;                        // Would clear enable if decoded
      write_reg(4'd5, w);
      check_frame();
   endtask

   task automatic horizontal_bars();
      wait_vblank();
      write_ctrl(1'b1, 1'b1);
      exp_mode = 1'b1;
      check_frame();
   endtask

   task automatic disable_and_restore();
      wait_vblank();
      write_ctrl(1'b0, 1'b0);
      exp_mode   = 1'b0;
      exp_enable = 1'b0;
      check_frame();                            // All black, syncs unchanged
      wait_vblank();
      write_ctrl(1'b0, 1'b1);
      exp_enable = 1'b1;
      check_frame();
   endtask

   initial begin
      reg_addr   = '0;
      reg_write  = 1'b0;
      reg_wdata  = '0;
      exp_enable = 1'b1;
      exp_mode   = 1'b0;
      exp_pal    = '{12'hfff, 12'hff0, 12'h0ff, 12'h0f0,
                     12'hf0f, 12'hf00, 12'h00f, 12'h000};
      lfsr       = 32'hfbae;
      test_errs  = 0;
      reset_levels();
      default_pattern();
      random_palette();
      horizontal_bars();
      disable_and_restore();
      $display("Frames checked %0d, pixels checked %0d, errors %0d",
               frames_checked, pix_cnt, mon_errs + test_errs);
      if (mon_errs + test_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all test frames were seen");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;        // 4 ns pixel clock
   end

   initial begin
      arst_n = 1'b0;
      repeat (3) @(posedge clk);    // Three cycles in reset
      @(negedge clk);
      arst_n = 1'b1;                // Release away from the active edge
   end

endmodule

/* design/video_daisy_system.sv */
`timescale 1ns/1ps

module video_daisy_system
   import video_pkg::*;
(
   input  logic                  pixel_clk,
   input  logic                  arst_n,
   // Register write port, one-cycle strobe
   input  logic [REG_ADDR_W-1:0] reg_addr,
   input  logic                  reg_write,
   input  bar_reg_u              reg_wdata,
   // VGA pins
   output logic [3:0]            vga_r,
   output logic [3:0]            vga_g,
   output logic [3:0]            vga_b,
   output logic                  vga_hsync,
   output logic                  vga_vsync,
   output logic                  vga_blank_n
);

   vga_timing_t tim;    // Raster position
   bar_cfg_t    cfg;    // Bar setup

   // ----------------------------------------------------------------------
   // Timing, then renderer, then pins
   // ----------------------------------------------------------------------
   vga_timing_gen u_vga_timing_gen (
      .pixel_clk (pixel_clk),
      .arst_n    (arst_n),
      .tim       (tim)
   );

   video_bar_regs u_video_bar_regs (
      .pixel_clk (pixel_clk),
      .arst_n    (arst_n),
      .reg_addr  (reg_addr),
      .reg_write (reg_write),
      .reg_wdata (reg_wdata),
      .cfg       (cfg)
   );

   video_bar_core u_video_bar_core (
      .pixel_clk   (pixel_clk),
      .arst_n      (arst_n),
      .tim         (tim),
      .cfg         (cfg),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_n (vga_blank_n)
   );

endmodule

/* design/video_bar_core.sv */
`timescale 1ns/1ps

module video_bar_core
   import video_pkg::*;
(
   input  logic        pixel_clk,
   input  logic        arst_n,
   input  vga_timing_t tim,
   input  bar_cfg_t    cfg,
   output logic [3:0]  vga_r,
   output logic [3:0]  vga_g,
   output logic [3:0]  vga_b,
   output logic        vga_hsync,
   output logic        vga_vsync,
   output logic        vga_blank_n
);

   // ----------------------------------------------------------------------
   // Bar index by boundary compare
   // ----------------------------------------------------------------------
   // Counts how many bar edges lie at or below pos
   function automatic logic [PAL_IDX_W-1:0] bar_index(
      input logic [CNT_W-1:0] pos,
      input logic [CNT_W-1:0] span
   );
      logic [PAL_IDX_W-1:0] idx;
      logic [CNT_W-1:0]     edge_pos;
      idx      = '0;
      edge_pos = span;                      // Start of bar 1
      for (int k = 1; k < NUM_BARS; k++) begin
         if (pos >= edge_pos) begin
            idx = PAL_IDX_W'(k);
         end
         edge_pos = edge_pos + span;
      end
      return idx;
   endfunction

   logic [PAL_IDX_W-1:0] idx_v;     // Column bars
   logic [PAL_IDX_W-1:0] idx_h;     // Row bars
   logic [PAL_IDX_W-1:0] idx;
   rgb444_t              pix_d;

   assign idx_v = bar_index(tim.x, BAR_W);
   assign idx_h = bar_index(tim.y, BAR_H);
   assign idx   = (cfg.mode == MODE_HORIZONTAL) ? idx_h : idx_v;

   always_comb begin
      // Black outside active area or when bars are off
      if (tim.active && cfg.enable) begin
         pix_d = cfg.palette[idx];
      end else begin
         pix_d = '0;
      end
   end

   // ----------------------------------------------------------------------
   // Output stage, colour and syncs share one register
   // ----------------------------------------------------------------------
   always_ff @(posedge pixel_clk or negedge arst_n) begin
      if (!arst_n) begin
         vga_r       <= '0;
         vga_g       <= '0;
         vga_b       <= '0;
         vga_hsync   <= ~SYNC_ACTIVE;      // Idle level
         vga_vsync   <= ~SYNC_ACTIVE;
         vga_blank_n <= 1'b0;              // Blanked
      end else begin
         vga_r       <= pix_d.r;
         vga_g       <= pix_d.g;
         vga_b       <= pix_d.b;
         vga_hsync   <= tim.hsync;         // Same delay as colour
         vga_vsync   <= tim.vsync;
         vga_blank_n <= tim.active;
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   a_blank_black: assert property (
      @(posedge pixel_clk) disable iff (!arst_n)
      !vga_blank_n |-> ({vga_r, vga_g, vga_b} == '0)
   ) else $error("colour %h%h%h during blanking", vga_r, vga_g, vga_b);

endmodule

/* design/video_bar_regs.sv */
`timescale 1ns/1ps

module video_bar_regs
   import video_pkg::*;
(
   input  logic                  pixel_clk,
   input  logic                  arst_n,
   input  logic [REG_ADDR_W-1:0] reg_addr,
   input  logic                  reg_write,
   input  bar_reg_u              reg_wdata,
   output bar_cfg_t              cfg
);

   // ----------------------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------------------
   logic                  ctrl_hit;
   logic                  pal_hit;
   logic [REG_ADDR_W-1:0] pal_offs;
   logic [PAL_IDX_W-1:0]  pal_idx;

   assign ctrl_hit = reg_write && (reg_addr == ADDR_CTRL);
   assign pal_hit  = reg_write && (reg_addr >= ADDR_PAL_BASE);   // 8..15

   // Offset from palette base picks the entry
   assign pal_offs = reg_addr - ADDR_PAL_BASE;
   assign pal_idx  = pal_offs[PAL_IDX_W-1:0];

   // ----------------------------------------------------------------------
   // Control word and palette storage
   // ----------------------------------------------------------------------
   always_ff @(posedge pixel_clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg.enable  <= ENABLE_DEFAULT;     // Bars on
         cfg.mode    <= MODE_VERTICAL;
         cfg.palette <= PAL_DEFAULT;
      end else begin
         if (ctrl_hit) begin
            // Control view of the write word
            cfg.enable <= reg_wdata.ctrl.enable;
            cfg.mode   <= reg_wdata.ctrl.mode;
         end
         if (pal_hit) begin
            cfg.palette[pal_idx] <= reg_wdata.pal.color;   // Palette view
         end
         // Addresses 1..7 fall through untouched
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   a_addr_known: assert property (
      @(posedge pixel_clk) disable iff (!arst_n)
      reg_write |-> !$isunknown(reg_addr)
   ) else $error("register write with unknown address %h", reg_addr);

endmodule

/* design/vga_timing_gen.sv */
`timescale 1ns/1ps

module vga_timing_gen
   import video_pkg::*;
(
   input  logic        pixel_clk,
   input  logic        arst_n,
   output vga_timing_t tim
);

   // ----------------------------------------------------------------------
   // Raster counters
   // ----------------------------------------------------------------------
   logic [CNT_W-1:0] h_cnt;      // Pixel within line
   logic [CNT_W-1:0] v_cnt;      // Line within frame
   logic             h_last;
   logic             v_last;
   logic             h_in_sync;
   logic             v_in_sync;
   vga_timing_t      tim_d;

   assign h_last = (h_cnt == H_TOTAL - 1'b1);
   assign v_last = (v_cnt == V_TOTAL - 1'b1);

   always_ff @(posedge pixel_clk or negedge arst_n) begin
      if (!arst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            // Vertical steps once per line
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Decode, one stage behind the counters
   // ----------------------------------------------------------------------
   // Sync pulse sits after active area and front porch
   assign h_in_sync = (h_cnt >= H_ACTIVE + H_FRONT) &&
                      (h_cnt <  H_ACTIVE + H_FRONT + H_SYNC);
   assign v_in_sync = (v_cnt >= V_ACTIVE + V_FRONT) &&
                      (v_cnt <  V_ACTIVE + V_FRONT + V_SYNC);

   always_comb begin
      tim_d.hsync  = h_in_sync ? SYNC_ACTIVE : ~SYNC_ACTIVE;
      tim_d.vsync  = v_in_sync ? SYNC_ACTIVE : ~SYNC_ACTIVE;
      tim_d.active = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
      tim_d.x      = h_cnt;     // Origin is first visible pixel
      tim_d.y      = v_cnt;
   end

   always_ff @(posedge pixel_clk or negedge arst_n) begin
      if (!arst_n) begin
         // Syncs idle, nothing visible
         tim <= '{hsync:  ~SYNC_ACTIVE,
                  vsync:  ~SYNC_ACTIVE,
                  active: 1'b0,
                  x:      '0,
                  y:      '0};
      end else begin
         tim <= tim_d;
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   a_cnt_range: assert property (
      @(posedge pixel_clk) disable iff (!arst_n)
      (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL)
   ) else $error("raster counter out of range h=%0d v=%0d", h_cnt, v_cnt);

   // Porches must keep the pulses out of the visible area
   a_active_no_sync: assert property (
      @(posedge pixel_clk) disable iff (!arst_n)
      tim.active |-> (tim.hsync != SYNC_ACTIVE) && (tim.vsync != SYNC_ACTIVE)
   ) else $error("sync pulse inside active area x=%0d y=%0d", tim.x, tim.y);

endmodule

/* design/video_pkg.sv */
package video_pkg;

   // ----------------------------------------------------------------------
   // Raster timing, 640x480 at 60 Hz
   // ----------------------------------------------------------------------
   localparam int CNT_W = 10;                           // Both counters

   localparam logic [CNT_W-1:0] H_ACTIVE = 10'd640;     // Visible pixels
   localparam logic [CNT_W-1:0] H_FRONT  = 10'd16;
   localparam logic [CNT_W-1:0] H_SYNC   = 10'd96;
   localparam logic [CNT_W-1:0] H_BACK   = 10'd48;
   localparam logic [CNT_W-1:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

   localparam logic [CNT_W-1:0] V_ACTIVE = 10'd480;     // Visible lines
   localparam logic [CNT_W-1:0] V_FRONT  = 10'd10;
   localparam logic [CNT_W-1:0] V_SYNC   = 10'd2;
   localparam logic [CNT_W-1:0] V_BACK   = 10'd33;
   localparam logic [CNT_W-1:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

   localparam logic SYNC_ACTIVE = 1'b0;                 // Both syncs active low

   // ----------------------------------------------------------------------
   // Colour bars
   // ----------------------------------------------------------------------
   localparam int NUM_BARS  = 8;
   localparam int PAL_IDX_W = $clog2(NUM_BARS);

   localparam logic [CNT_W-1:0] BAR_W = 10'd80;         // H_ACTIVE / NUM_BARS
   localparam logic [CNT_W-1:0] BAR_H = 10'd60;         // V_ACTIVE / NUM_BARS

   localparam logic MODE_VERTICAL   = 1'b0;             // Bars split along x
   localparam logic MODE_HORIZONTAL = 1'b1;             // Bars split along y

   // ----------------------------------------------------------------------
   // Register map
   // ----------------------------------------------------------------------
   localparam int REG_ADDR_W = 4;

   localparam logic [REG_ADDR_W-1:0] ADDR_CTRL     = 4'd0;
   localparam logic [REG_ADDR_W-1:0] ADDR_PAL_BASE = 4'd8;   // Entries at 8..15

   // 4 bits per channel
   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb444_t;

   // Raster position and syncs, one pixel per cycle
   typedef struct packed {
      logic             hsync;
      logic             vsync;
      logic             active;
      logic [CNT_W-1:0] x;        // Valid while active
      logic [CNT_W-1:0] y;
   } vga_timing_t;

   typedef struct packed {
      logic [29:0] rsvd;
      logic        mode;
      logic        enable;
   } bar_ctrl_t;

   typedef struct packed {
      logic [19:0] rsvd;
      rgb444_t     color;
   } bar_pal_t;

   // Write data seen as control word or palette entry
   typedef union packed {
      bar_ctrl_t ctrl;
      bar_pal_t  pal;
   } bar_reg_u;

   typedef struct packed {
      logic                     enable;
      logic                     mode;
      rgb444_t [NUM_BARS-1:0]   palette;
   } bar_cfg_t;

   // Entry 0 sits in the low bits, so white is last here
   localparam rgb444_t [NUM_BARS-1:0] PAL_DEFAULT = {
      12'h000, 12'h00f, 12'hf00, 12'hf0f,   // Black, blue, red, magenta
      12'h0f0, 12'h0ff, 12'hff0, 12'hfff    // Green, cyan, yellow, white
   };

   localparam logic ENABLE_DEFAULT = 1'b1;

endpackage
